// ==== all.f ====
serial_pkg.sv
serial_clk_gen.sv
tx_word_buffer.sv
serial_shifter.sv
serial_link_top.sv
serial_link_sva.sv
tb_serial_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the serial link testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_serial_link -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_serial_link +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "testbench reported failure"
	exit 1
fi

echo "simulation finished without a reported failure"
exit 0

// ==== tb_serial_link.sv ====
// testbench with clock, reset, credit-limited random bursts, sdo loopback and scoreboard
`timescale 1ns/1ns

module tb_serial_link;
	import serial_pkg::*;

	logic         in_clk;
	logic         in_rst;
	tx_req_t      tx_req;
	logic         tx_credit;
	serial_pins_t pins;
	logic         sdi;
	rx_word_t     rx;

	// host side bookkeeping
	int seed;
	int credits;
	int words_pushed;
	int credits_returned;
	bit timed_out;

	// scoreboard
	word_t sent_q[$];
	int    words_received;
	int    errors;
	// falling sclk edges within the current word
	int    fall_idx;
	logic  sclk_prev;

	// burst control
	int burst;
	int burst_len;
	int pushed;
	int wait_cnt;
	int gap;
	bit pace_slow;
	bit did_push;

	serial_link_top DUT (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.tx_req    (tx_req),
		.tx_credit (tx_credit),
		.pins      (pins),
		.sdi       (sdi),
		.rx        (rx)
	);

	// data out wired straight back to data in
	assign sdi = pins.sdo;

	// 8 ns period
	initial begin
		in_clk = 1'b0;
		forever begin
			#4 in_clk = ~in_clk;
		end
	end

	// one host clock that counts returned credits and may push a word
	task automatic drive_cycle(input bit want_push, output bit pushed_now);
		word_t w;
		@(posedge in_clk);
		pushed_now = 1'b0;
		if (tx_credit) begin
			credits++;
			credits_returned++;
		end
		assert (credits <= BUF_DEPTH) else begin
			$display("ERROR at %0t: host credit count %0d is above the buffer depth",
				$time, credits);
			errors++;
		end
		if (want_push && credits > 0) begin
			w = word_t'($random(seed));
			tx_req.valid <= 1'b1;
			tx_req.word  <= w;
			sent_q.push_back(w);
			credits--;
			words_pushed++;
			pushed_now = 1'b1;
		end else begin
			tx_req.valid <= 1'b0;
		end
	endtask

	// output monitor sampling at the clock edge
	always @(posedge in_clk) begin
		word_t    exp_word;
		bit_idx_t bit_pos;
		if (!in_rst) begin
			if (rx.valid) begin
				words_received++;
				if (sent_q.size() == 0) begin
					$display("ERROR at %0t: rx word %h arrived with nothing outstanding",
						$time, rx.word);
					errors++;
				end else begin
					exp_word = sent_q.pop_front();
					assert (rx.word == exp_word) else begin
						$display("MISMATCH time=%0t signal=rx.word expected=%h actual=%h",
							$time, exp_word, rx.word);
						errors++;
					end
				end
			end
			// each falling sclk puts the next bit on sdo with bit 0 first
			if (sclk_prev == 1'b1 && pins.sclk == 1'b0) begin
				bit_pos = LSB_FIRST ? bit_idx_t'(fall_idx) : bit_idx_t'(WORD_BITS - 1 - fall_idx);
				if (sent_q.size() == 0) begin
					$display("ERROR at %0t: sclk fell with no word being sent", $time);
					errors++;
				end else begin
					exp_word = sent_q[0];
					assert (pins.sdo == exp_word[bit_pos]) else begin
						$display("MISMATCH time=%0t signal=pins.sdo expected=%b actual=%b",
							$time, exp_word[bit_pos], pins.sdo);
						errors++;
					end
				end
				fall_idx = (fall_idx + 1) % WORD_BITS;
			end
			sclk_prev = pins.sclk;
		end
	end

	initial begin
		in_rst = 1'b1;
		tx_req = '0;
		seed = 16994;
		credits = BUF_DEPTH;
		words_pushed = 0;
		credits_returned = 0;
		words_received = 0;
		errors = 0;
		fall_idx = 0;
		sclk_prev = SCLK_IDLE;
		timed_out = 1'b0;
		did_push = 1'b0;
		repeat (4) @(posedge in_clk);
		in_rst <= 1'b0;

		burst = 0;
		while (burst < 12 && !timed_out) begin
			burst_len = 1 + ($random(seed) & 7);
			pace_slow = ($random(seed) & 1) != 0;
			pushed = 0;
			wait_cnt = 0;
			// slow bursts try a push on about half the cycles
			while (pushed < burst_len && !timed_out) begin
				drive_cycle(!pace_slow || (($random(seed) & 1) != 0), did_push);
				if (did_push) begin
					pushed++;
				end
				wait_cnt++;
				if (wait_cnt > 1000) begin
					$display("timeout: burst %0d could not push all its words", burst);
					timed_out = 1'b1;
				end
			end
			// drain until every sent word has come back
			wait_cnt = 0;
			while (sent_q.size() != 0 && !timed_out) begin
				drive_cycle(1'b0, did_push);
				wait_cnt++;
				if (wait_cnt > 1000) begin
					$display("timeout: link did not drain after burst %0d", burst);
					timed_out = 1'b1;
				end
			end
			// idle gap before the next burst
			gap = 3 + ($random(seed) & 15);
			repeat (gap) drive_cycle(1'b0, did_push);
			burst++;
		end

		assert (words_received == words_pushed) else begin
			$display("MISMATCH time=%0t signal=words_received expected=%0d actual=%0d",
				$time, words_pushed, words_received);
			errors++;
		end
		assert (credits_returned == words_pushed) else begin
			$display("MISMATCH time=%0t signal=credits_returned expected=%0d actual=%0d",
				$time, words_pushed, credits_returned);
			errors++;
		end

		$display("pushed=%0d received=%0d credits=%0d scoreboard_errors=%0d sva_failures=%0d",
			words_pushed, words_received, credits_returned, errors, DUT.u_sva.fail_cnt);
		if (errors == 0 && DUT.u_sva.fail_cnt == 0 && !timed_out) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== serial_link_sva.sv ====
// concurrent checks on idle pin levels, sdo edges, start latency and word spacing, with bind
`timescale 1ns/1ns

module serial_link_sva (
	input logic                     in_clk,
	input logic                     in_rst,
	input serial_pkg::tx_req_t      tx_req,
	input logic                     buf_avail,
	input logic                     run,
	input serial_pkg::serial_pins_t pins,
	input serial_pkg::rx_word_t     rx
);
	import serial_pkg::*;

	// failures so far
	int fail_cnt = 0;

	// no transaction, both wires parked
	idle_levels_a: assert property (@(posedge in_clk) disable iff (in_rst)
		!run |-> (pins.sclk == SCLK_IDLE) && (pins.sdo == SDATA_IDLE))
	else begin
		fail_cnt++;
		$error("sclk or sdo away from its idle level while the link is idle");
	end

	// inside a transaction sdo only moves together with a falling sclk
	sdo_on_fall_a: assert property (@(posedge in_clk) disable iff (in_rst)
		(run && $past(run) && (pins.sdo != $past(pins.sdo))) |-> $fell(pins.sclk))
	else begin
		fail_cnt++;
		$error("sdo changed without a falling sclk");
	end

	// sclk low for two samples, data must hold
	sdo_stable_low_a: assert property (@(posedge in_clk) disable iff (in_rst)
		(!pins.sclk && !$past(pins.sclk)) |-> $stable(pins.sdo))
	else begin
		fail_cnt++;
		$error("sdo moved while sclk was low");
	end

	// two cycles from a push into an empty idle link to run
	start_latency_a: assert property (@(posedge in_clk) disable iff (in_rst)
		(tx_req.valid && !run && !buf_avail) |-> ##2 run)
	else begin
		fail_cnt++;
		$error("link did not start shifting after a push into an empty buffer");
	end

	// run still high at a done pulse means the next word is already loaded
	word_spacing_a: assert property (@(posedge in_clk) disable iff (in_rst)
		(rx.valid && run) |-> ##64 rx.valid)
	else begin
		fail_cnt++;
		$error("back-to-back rx words were not 64 cycles apart");
	end

	// done is a single-cycle pulse
	rx_pulse_a: assert property (@(posedge in_clk) disable iff (in_rst)
		rx.valid |=> !rx.valid)
	else begin
		fail_cnt++;
		$error("rx valid held for more than one cycle");
	end

endmodule

bind serial_link_top serial_link_sva u_sva (
	.in_clk    (in_clk),
	.in_rst    (in_rst),
	.tx_req    (tx_req),
	.buf_avail (buf_avail),
	.run       (run),
	.pins      (pins),
	.rx        (rx)
);

// ==== serial_link_top.sv ====
// three-wire serial master built from buffer, clock divider and shifter
`timescale 1ns/1ns

module serial_link_top (
	input  logic                     in_clk,
	input  logic                     in_rst,
	input  serial_pkg::tx_req_t      tx_req,
	output logic                     tx_credit,
	output serial_pkg::serial_pins_t pins,
	input  logic                     sdi,
	output serial_pkg::rx_word_t     rx
);
	import serial_pkg::*;

	// buffer to shifter
	word_t buf_word;
	logic  buf_avail;
	logic  buf_pop;

	// divider to shifter
	logic half_tick;
	logic phase_high;
	// shifter to divider
	logic run;

	// host words wait here
	tx_word_buffer u_buf (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.tx_req    (tx_req),
		.buf_pop   (buf_pop),
		.buf_word  (buf_word),
		.buf_avail (buf_avail),
		.tx_credit (tx_credit)
	);

	// half-period ticks, running only during a transaction
	serial_clk_gen u_clk_gen (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.run        (run),
		.half_tick  (half_tick),
		.phase_high (phase_high)
	);

	// serial engine, drives the pins and returns received words
	serial_shifter u_shifter (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.buf_word   (buf_word),
		.buf_avail  (buf_avail),
		.buf_pop    (buf_pop),
		.half_tick  (half_tick),
		.phase_high (phase_high),
		.run        (run),
		.sdi        (sdi),
		.pins       (pins),
		.rx         (rx)
	);

endmodule

// ==== serial_shifter.sv ====
// shift FSM that sends words on sdo, samples sdi and holds the idle levels
`timescale 1ns/1ns

module serial_shifter (
	input  logic                     in_clk,
	input  logic                     in_rst,
	input  serial_pkg::word_t        buf_word,
	input  logic                     buf_avail,
	output logic                     buf_pop,
	input  logic                     half_tick,
	input  logic                     phase_high,
	output logic                     run,
	input  logic                     sdi,
	output serial_pkg::serial_pins_t pins,
	output serial_pkg::rx_word_t     rx
);
	import serial_pkg::*;

	// state
	link_state_t state;

	// word being sent
	word_t tx_word;
	// word being received, complete after the last sample
	word_t rx_shift;
	// receive word with the current sample merged in
	word_t rx_next;
	// one-cycle done flag
	logic rx_valid;

	// bits done in this word
	bit_idx_t bit_cnt;
	// bit position after ordering
	bit_idx_t bit_sel;

	// registered data-in
	logic sdi_q;
	// registered data-out
	logic sdo_q;

	// tick decode
	logic launch_tick;
	logic sample_tick;
	logic last_bit;
	logic word_done;

	// phase high during a tick means sclk is about to fall
	assign launch_tick = (state == LINK_SHIFT) && half_tick && phase_high;
	// phase low means sclk is about to rise
	assign sample_tick = (state == LINK_SHIFT) && half_tick && !phase_high;

	assign last_bit  = (bit_cnt == bit_idx_t'(WORD_BITS - 1));
	assign word_done = sample_tick && last_bit;

	// same counter for send and receive, only the order differs
	assign bit_sel = LSB_FIRST ? bit_cnt : bit_idx_t'(WORD_BITS - 1) - bit_cnt;

	// merge the sampled bit into the receive word
	always_comb begin
		rx_next          = rx_shift;
		rx_next[bit_sel] = sdi_q;
	end

	// word fetch
	// in shift, the next word is taken on the last sample tick
	// so words follow without a gap
	always_comb begin
		case (state)
			LINK_IDLE: begin
				buf_pop = buf_avail;
			end
			LINK_SHIFT: begin
				buf_pop = word_done && buf_avail;
			end
			default: begin
				buf_pop = 1'b0;
			end
		endcase
	end

	// control
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state    <= LINK_IDLE;
			run      <= 1'b0;
			bit_cnt  <= '0;
			sdo_q    <= SDATA_IDLE;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= word_done;
			case (state)
				LINK_IDLE: begin
					// start the divider together with the first word
					if (buf_avail) begin
						state   <= LINK_SHIFT;
						run     <= 1'b1;
						bit_cnt <= '0;
					end
				end
				LINK_SHIFT: begin
					// new bit goes out as sclk falls
					if (launch_tick) begin
						sdo_q <= tx_word[bit_sel];
					end
					if (sample_tick) begin
						if (last_bit) begin
							bit_cnt <= '0;
							// buffer empty, end of transaction
							if (!buf_avail) begin
								state <= LINK_IDLE;
								run   <= 1'b0;
								sdo_q <= SDATA_IDLE;
							end
						end else begin
							bit_cnt <= bit_cnt + bit_idx_t'(1);
						end
					end
				end
				default: begin
					state <= LINK_IDLE;
					run   <= 1'b0;
				end
			endcase
		end
	end

	// data path
	always_ff @(posedge in_clk) begin
		sdi_q <= sdi;
		if (buf_pop) begin
			tx_word <= buf_word;
		end
		// sdi_q is sampled as sclk rises
		if (sample_tick) begin
			rx_shift <= rx_next;
		end
	end

	// pins held at idle outside a transaction
	always_comb begin
		pins.sclk = (state == LINK_SHIFT) ? (phase_high == SCLK_IDLE) : SCLK_IDLE;
		pins.sdo  = (state == LINK_SHIFT) ? sdo_q : SDATA_IDLE;
	end

	// rx_shift stays put until the next sample tick, at least a half period later
	assign rx.valid = rx_valid;
	assign rx.word  = rx_shift;

endmodule

// ==== tx_word_buffer.sv ====
// transmit word FIFO with one credit returned per popped word
`timescale 1ns/1ns

module tx_word_buffer (
	input  logic                in_clk,
	input  logic                in_rst,
	input  serial_pkg::tx_req_t tx_req,
	input  logic                buf_pop,
	output serial_pkg::word_t   buf_word,
	output logic                buf_avail,
	output logic                tx_credit
);
	import serial_pkg::*;

	// word storage
	word_t mem [BUF_DEPTH];

	// circular pointers
	buf_ptr_t wr_ptr;
	buf_ptr_t rd_ptr;

	// words currently held
	credit_t fill;

	// qualified push and pop
	logic push;
	logic pop;

	// host keeps to its credits, so a push never meets a full buffer
	assign push = tx_req.valid;
	// pop only counts when a word is there
	assign pop = buf_pop && buf_avail;

	// not empty
	assign buf_avail = (fill != '0);
	// head word, read without latency
	assign buf_word = mem[rd_ptr];

	// each word leaving frees one entry
	assign tx_credit = pop;

	// storage write
	always_ff @(posedge in_clk) begin
		if (push) begin
			mem[wr_ptr] <= tx_req.word;
		end
	end

	// write pointer
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			wr_ptr <= '0;
		end else if (push) begin
			if (wr_ptr == buf_ptr_t'(BUF_DEPTH - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + buf_ptr_t'(1);
			end
		end
	end

	// read pointer
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			if (rd_ptr == buf_ptr_t'(BUF_DEPTH - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + buf_ptr_t'(1);
			end
		end
	end

	// fill count
	// push and pop together leave it unchanged
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			fill <= '0;
		end else begin
			case ({push, pop})
				2'b10: begin
					fill <= fill + credit_t'(1);
				end
				2'b01: begin
					fill <= fill - credit_t'(1);
				end
				default: begin
					fill <= fill;
				end
			endcase
		end
	end

endmodule

// ==== serial_clk_gen.sv ====
// serial clock divider giving half-period tick enables and the clock phase
`timescale 1ns/1ns

module serial_clk_gen (
	input  logic in_clk,
	input  logic in_rst,
	input  logic run,
	output logic half_tick,
	output logic phase_high
);
	import serial_pkg::*;

	// cycles elapsed in the current half period
	half_cnt_t half_cnt;
	// last cycle of a half period
	logic half_end;

	assign half_end = (half_cnt == half_cnt_t'(HALF_PERIOD_CYCLES - 1));

	// tick is registered, so the first one lands a full
	// half period after run goes high
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			half_cnt   <= '0;
			half_tick  <= 1'b0;
			phase_high <= 1'b1;
		end else if (!run) begin
			// parked, divider cleared and phase back at the idle side
			half_cnt   <= '0;
			half_tick  <= 1'b0;
			phase_high <= 1'b1;
		end else begin
			half_tick <= half_end;
			if (half_end) begin
				half_cnt <= '0;
			end else begin
				half_cnt <= half_cnt + half_cnt_t'(1);
			end
			// phase flips right after each tick
			// so during a tick it still shows the old level
			if (half_tick) begin
				phase_high <= ~phase_high;
			end
		end
	end

endmodule

// ==== serial_pkg.sv ====
// shared widths, link constants, data types, state enum and bus structs
package serial_pkg;

	// word format
	localparam int WORD_BITS = 8;
	// bit order, 1 sends bit 0 first
	localparam logic LSB_FIRST = 1'b1;

	// transmit buffer depth, also the host start credit
	localparam int BUF_DEPTH = 4;

	// in_clk cycles per serial clock half period
	localparam int HALF_PERIOD_CYCLES = 4;

	// pin levels between transactions
	localparam logic SCLK_IDLE  = 1'b1;
	localparam logic SDATA_IDLE = 1'b1;

	// one parallel word
	typedef logic [WORD_BITS-1:0] word_t;
	// credit and fill count, 0 .. BUF_DEPTH
	typedef logic [$clog2(BUF_DEPTH + 1)-1:0] credit_t;
	// buffer read and write index
	typedef logic [$clog2(BUF_DEPTH)-1:0] buf_ptr_t;
	// bit position inside a word
	typedef logic [$clog2(WORD_BITS)-1:0] bit_idx_t;
	// clock divider count
	typedef logic [$clog2(HALF_PERIOD_CYCLES)-1:0] half_cnt_t;

	// shifter states
	typedef enum logic {
		LINK_IDLE,
		LINK_SHIFT
	} link_state_t;

	// host push into the transmit buffer
	typedef struct packed {
		logic  valid;
		word_t word;
	} tx_req_t;

	// word captured from the data-in line
	typedef struct packed {
		logic  valid;
		word_t word;
	} rx_word_t;

	// outgoing serial wires
	typedef struct packed {
		logic sclk;
		logic sdo;
	} serial_pins_t;

endpackage
